/* logic/vga_timing_pkg.sv */
package vga_timing_pkg;

  ////////////////////
  // Counter types
  ////////////////////

  // Pixel position within one line, blanking included
  typedef logic [9:0] h_count_t;

  // Line position within one frame
  typedef logic [9:0] v_count_t;

  ////////////////////
  // 640x480 at 60 Hz from a 25 MHz pixel clock
  ////////////////////

  // Horizontal, in pixel clocks
  localparam h_count_t h_total        = 10'd800;
  localparam h_count_t h_sync_len     = 10'd96;
  localparam h_count_t h_active_start = 10'd144;

  // Exclusive bound
  localparam h_count_t h_active_end   = 10'd784;

  // Vertical, in lines
  localparam v_count_t v_total        = 10'd525;
  localparam v_count_t v_sync_len     = 10'd2;
  localparam v_count_t v_active_start = 10'd35;

  // Exclusive bound
  localparam v_count_t v_active_end   = 10'd515;

endpackage

/* logic/board_pkg.sv */
package board_pkg;

  ////////////////////
  // Board geometry
  ////////////////////

  localparam int board_cols = 10;
  localparam int board_rows = 20;

  // One bit per cell at index row * board_cols + col
  // Row 0 is the top row
  typedef logic [board_cols*board_rows-1:0] board_t;

  typedef logic [3:0] col_idx_t;
  typedef logic [4:0] row_idx_t;

  // Flat bit index into board_t
  typedef logic [7:0] cell_idx_t;

  // Coordinate inside the visible 640x480 area
  typedef logic [9:0] pixel_pos_t;

  localparam pixel_pos_t cell_size    = 10'd24;
  localparam pixel_pos_t board_left   = 10'd200;
  localparam pixel_pos_t board_width  = pixel_pos_t'(board_cols) * cell_size;
  localparam pixel_pos_t board_height = pixel_pos_t'(board_rows) * cell_size;

  ////////////////////
  // Colours
  ////////////////////

  // Red in the top nibble, then green and blue
  typedef logic [11:0] rgb_t;

  localparam rgb_t color_lit   = 12'hFFF;
  localparam rgb_t color_empty = 12'h00F;
  localparam rgb_t color_black = 12'h000;

endpackage

/* logic/scan_timing.sv */
module scan_timing (
  input  logic                   clk_n,
  input  logic                   clr,
  output vga_timing_pkg::h_count_t h_count,
  output vga_timing_pkg::v_count_t v_count,
  output logic                   hsync,
  output logic                   vsync,
  output logic                   active,
  output board_pkg::pixel_pos_t  x_pos,
  output board_pkg::pixel_pos_t  y_pos
);

  import vga_timing_pkg::*;

  logic     h_wrap;
  logic     v_wrap;
  h_count_t h_next;
  v_count_t v_next;

  ////////////////////
  // Scan counters
  ////////////////////

  assign h_wrap = (h_count == h_total - 10'd1);
  assign v_wrap = (v_count == v_total - 10'd1);

  always_comb begin
    h_next = h_wrap ? '0 : h_count + 10'd1;
    v_next = v_count;
    if (h_wrap) begin
      v_next = v_wrap ? '0 : v_count + 10'd1;
    end
  end

  // Syncs are decoded from the next count so they line up with the counters
  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      h_count <= '0;
      v_count <= '0;
      hsync   <= 1'b0;
      vsync   <= 1'b0;
    end else begin
      h_count <= h_next;
      v_count <= v_next;
      hsync   <= (h_next >= h_sync_len);
      vsync   <= (v_next >= v_sync_len);
    end
  end

  ////////////////////
  // Active window
  ////////////////////

  assign active = (h_count >= h_active_start) && (h_count < h_active_end) &&
                  (v_count >= v_active_start) && (v_count < v_active_end);

  // Wraps to large values in blanking
  assign x_pos = h_count - h_active_start;
  assign y_pos = v_count - v_active_start;

  ////////////////////
  // Checks
  ////////////////////

  a_h_range : assert property (@(posedge clk_n) disable iff (clr)
    h_count <= h_total - 10'd1);

  a_v_range : assert property (@(posedge clk_n) disable iff (clr)
    v_count <= v_total - 10'd1);

  // Registered sync must track the counter every cycle
  a_hsync_align : assert property (@(posedge clk_n) disable iff (clr)
    hsync == (h_count >= h_sync_len));

  a_vsync_align : assert property (@(posedge clk_n) disable iff (clr)
    vsync == (v_count >= v_sync_len));

endmodule

/* logic/cell_locator.sv */
module cell_locator (
  input  board_pkg::pixel_pos_t x_pos,
  input  board_pkg::pixel_pos_t y_pos,
  output board_pkg::col_idx_t   col,
  output board_pkg::row_idx_t   row,
  output logic                  in_board
);

  import board_pkg::*;

  pixel_pos_t x_off;
  pixel_pos_t col_full;
  pixel_pos_t row_full;

  ////////////////////
  // Board-relative position
  ////////////////////

  // Left of the board this wraps above board_width
  assign x_off = x_pos - board_left;

  assign col_full = x_off / cell_size;
  assign row_full = y_pos / cell_size;

  // Only meaningful while in_board is high
  assign col = col_idx_t'(col_full);
  assign row = row_idx_t'(row_full);

  // The row test only matters in vertical blanking
  assign in_board = (x_off < board_width) && (y_pos < board_height);

endmodule

/* logic/pixel_shader.sv */
module pixel_shader (
  input  logic                clk_n,
  input  logic                clr,
  input  logic                active,
  input  logic                in_board,
  input  board_pkg::col_idx_t col,
  input  board_pkg::row_idx_t row,
  input  board_pkg::board_t   board,
  output logic [3:0]          red,
  output logic [3:0]          green,
  output logic [3:0]          blue
);

  import board_pkg::*;

  cell_idx_t cell_idx;
  logic      cell_lit;
  rgb_t      color_next;
  rgb_t      color_q;

  ////////////////////
  // Cell lookup
  ////////////////////

  assign cell_idx = cell_idx_t'(row) * cell_idx_t'(board_cols) + cell_idx_t'(col);
  assign cell_lit = board[cell_idx];

  always_comb begin
    if (!active || !in_board) begin
      color_next = color_black;
    end else if (cell_lit) begin
      color_next = color_lit;
    end else begin
      color_next = color_empty;
    end
  end

  // One cycle behind the scan position
  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      color_q <= color_black;
    end else begin
      color_q <= color_next;
    end
  end

  assign red   = color_q[11:8];
  assign green = color_q[7:4];
  assign blue  = color_q[3:0];

  // Locator must never point outside the board word
  a_cell_in_range : assert property (@(posedge clk_n) disable iff (clr)
    in_board |-> (col < board_cols) && (row < board_rows));

endmodule

/* logic/vga_board_display.sv */
module vga_board_display (
  input  logic              clk_n,
  input  logic              clr,
  input  board_pkg::board_t board,
  output logic              hsync,
  output logic              vsync,
  output logic [3:0]        red,
  output logic [3:0]        green,
  output logic [3:0]        blue
);

  import vga_timing_pkg::*;
  import board_pkg::*;

  h_count_t   h_count;
  v_count_t   v_count;
  logic       active;
  pixel_pos_t x_pos;
  pixel_pos_t y_pos;
  col_idx_t   col;
  row_idx_t   row;
  logic       in_board;
  logic       prev_blank;

  scan_timing u_scan_timing (
    .clk_n   (clk_n),
    .clr     (clr),
    .h_count (h_count),
    .v_count (v_count),
    .hsync   (hsync),
    .vsync   (vsync),
    .active  (active),
    .x_pos   (x_pos),
    .y_pos   (y_pos)
  );

  cell_locator u_cell_locator (
    .x_pos    (x_pos),
    .y_pos    (y_pos),
    .col      (col),
    .row      (row),
    .in_board (in_board)
  );

  pixel_shader u_pixel_shader (
    .clk_n    (clk_n),
    .clr      (clr),
    .active   (active),
    .in_board (in_board),
    .col      (col),
    .row      (row),
    .board    (board),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  // Count one clock back was in blanking
  assign prev_blank = (h_count <= h_active_start) || (h_count > h_active_end) ||
                      (v_count < v_active_start) || (v_count >= v_active_end);

  a_blank_black : assert property (@(posedge clk_n) disable iff (clr)
    prev_blank |-> ({red, green, blue} == color_black));

endmodule

/* testbench/tb_vga_board_display.sv */
module tb_vga_board_display;
  timeunit 1ns;
  timeprecision 1ps;

  import vga_timing_pkg::*;
  import board_pkg::*;

  localparam int frame_clocks = int'(h_total) * int'(v_total);
  localparam int wait_limit   = frame_clocks + 1000;

  logic       clk_n = 1'b0;
  logic       clr   = 1'b1;
  board_t     board = '0;
  logic       hsync;
  logic       vsync;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;

  // Scan position model valid at each falling edge
  int     h_m         = 0;
  int     v_m         = 0;
  logic   clr_last    = 1'b1;
  logic   hsync_last  = 1'b0;
  int     check_count = 0;
  int     error_count = 0;
  integer seed        = 32'h936c_d475;
  event   sampled;

  vga_board_display u_vga_board_display (
    .clk_n (clk_n),
    .clr   (clr),
    .board (board),
    .hsync (hsync),
    .vsync (vsync),
    .red   (red),
    .green (green),
    .blue  (blue)
  );

  initial begin
    forever #10 clk_n = ~clk_n;
  end

  ////////////////////
  // Position model
  ////////////////////

  always @(negedge clk_n) begin
    if (clr || clr_last) begin
      h_m = 0;
      v_m = 0;
    end else begin
      if (h_m == int'(h_total) - 1) begin
        h_m = 0;
        v_m = (v_m == int'(v_total) - 1) ? 0 : v_m + 1;
      end else begin
        h_m = h_m + 1;
      end
      // Falling hsync marks the start of a line
      if (hsync_last && !hsync) begin
        if (h_m != 0) begin
          error_count++;
          $display("Fail h position at hsync fall: got %0h expected 0", h_m);
        end
        h_m = 0;
      end
    end
    clr_last   = clr;
    hsync_last = hsync;
    -> sampled;
  end

  function automatic rgb_t expected_color(input int h, input int v, input board_t b);
    int x;
    int y;
    if (h < int'(h_active_start) || h >= int'(h_active_end) ||
        v < int'(v_active_start) || v >= int'(v_active_end)) begin
      return color_black;
    end
    x = h - int'(h_active_start);
    y = v - int'(v_active_start);
    if (x < int'(board_left) || x >= int'(board_left) + board_cols * int'(cell_size)) begin
      return color_black;
    end
    x = (x - int'(board_left)) / int'(cell_size);
    y = y / int'(cell_size);
    return b[y * board_cols + x] ? color_lit : color_empty;
  endfunction

  // Counter value at the centre of a cell
  function automatic int cell_h(input int c);
    return int'(h_active_start) + int'(board_left) + c * int'(cell_size) + int'(cell_size) / 2;
  endfunction

  function automatic int cell_v(input int r);
    return int'(v_active_start) + r * int'(cell_size) + int'(cell_size) / 2;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic wait_scan(input int h, input int v);
    int n;
    n = 0;
    do begin
      @(sampled);
      n++;
    end while (!(h_m == h && v_m == v) && n < wait_limit);
    if (h_m != h || v_m != v) begin
      error_count++;
      $display("Timed out waiting for scan position h=%0d v=%0d", h, v);
    end
  endtask

  // Colour of (h, v) shows one clock later
  task automatic check_pixel(input int h, input int v);
    wait_scan(h + 1, v);
    check_value($sformatf("rgb at h=%0d v=%0d", h, v), {red, green, blue},
                expected_color(h, v, board));
  endtask

  task automatic measure_run(input bit use_vsync, input logic level, output int n);
    n = 0;
    while (((use_vsync ? vsync : hsync) === level) && n < wait_limit) begin
      n++;
      @(sampled);
    end
    if (n >= wait_limit) begin
      error_count++;
      $display("Timed out while the %s pulse stayed at %b", use_vsync ? "vsync" : "hsync", level);
    end
  endtask

  task automatic check_line_timing();
    int n;
    check_value("hsync", hsync, 0);
    check_value("vsync", vsync, 0);
    check_value("rgb", {red, green, blue}, color_black);
    measure_run(1'b0, 1'b0, n);
    check_value("hsync low clocks", n, int'(h_sync_len));
    measure_run(1'b0, 1'b1, n);
    check_value("hsync high clocks", n, int'(h_total) - int'(h_sync_len));
    measure_run(1'b0, 1'b0, n);
    check_value("hsync low clocks", n, int'(h_sync_len));
  endtask

  task automatic set_board(input board_t b);
    @(posedge clk_n);
    board <= b;
    @(posedge clk_n);
  endtask

  task automatic make_random_board(output board_t b);
    b = '0;
    for (int i = 0; i < 7; i++) begin
      b = {b[$bits(board_t)-33:0], 32'($random(seed))};
    end
  endtask

  task automatic check_cell_centres();
    for (int r = 0; r < board_rows; r++) begin
      for (int c = 0; c < board_cols; c++) begin
        check_pixel(cell_h(c), cell_v(r));
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("Test %s done with %0d errors", name, error_count - errs_before);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_timing();
    int errs;
    errs = error_count;
    repeat (8) @(posedge clk_n);
    clr <= 1'b0;
    @(sampled);
    check_line_timing();
    finish_test("reset and hsync", errs);
  endtask

  task automatic test_vsync();
    int errs;
    int n;
    errs = error_count;
    measure_run(1'b1, 1'b0, n);
    measure_run(1'b1, 1'b1, n);
    check_value("vsync high clocks", n, (int'(v_total) - int'(v_sync_len)) * int'(h_total));
    measure_run(1'b1, 1'b0, n);
    check_value("vsync low clocks", n, int'(v_sync_len) * int'(h_total));
    finish_test("vsync", errs);
  endtask

  task automatic test_empty_board();
    int errs;
    errs = error_count;
    set_board('0);
    check_pixel(100, 10);
    check_pixel(144, 50);
    check_pixel(343, 50);
    check_pixel(344, 50);
    check_pixel(583, 50);
    check_pixel(584, 50);
    check_pixel(783, 50);
    check_pixel(784, 50);
    check_pixel(344, 514);
    check_pixel(583, 514);
    check_pixel(400, 520);
    finish_test("empty board", errs);
  endtask

  task automatic test_single_cell();
    int     errs;
    board_t b;
    errs = error_count;
    b = '0;
    b[3 * board_cols + 7] = 1'b1;
    set_board(b);
    // Neighbours and edges of cell (3, 7) in scan order
    check_pixel(cell_h(7), cell_v(2));
    check_pixel(cell_h(6), cell_v(3));
    check_pixel(cell_h(7) - 13, cell_v(3));
    check_pixel(cell_h(7) - 12, cell_v(3));
    check_pixel(cell_h(7), cell_v(3));
    check_pixel(cell_h(7) + 11, cell_v(3));
    check_pixel(cell_h(7) + 12, cell_v(3));
    check_pixel(cell_h(8), cell_v(3));
    check_pixel(cell_h(7), cell_v(4));
    finish_test("single cell", errs);
  endtask

  task automatic test_random_board();
    int     errs;
    board_t b;
    errs = error_count;
    make_random_board(b);
    set_board(b);
    check_cell_centres();
    make_random_board(b);
    set_board(b);
    check_cell_centres();
    finish_test("random board", errs);
  endtask

  task automatic test_midline_clear();
    int errs;
    errs = error_count;
    wait_scan(401, 100);
    @(posedge clk_n);
    clr <= 1'b1;
    @(sampled);
    check_value("hsync", hsync, 0);
    check_value("vsync", vsync, 0);
    check_value("rgb", {red, green, blue}, color_black);
    repeat (8) @(posedge clk_n);
    clr <= 1'b0;
    @(sampled);
    check_line_timing();
    finish_test("mid-line clear", errs);
  endtask

  initial begin
    test_reset_timing();
    test_vsync();
    test_empty_board();
    test_single_cell();
    test_random_board();
    test_midline_clear();
    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/vga_timing_pkg.sv
logic/board_pkg.sv
logic/scan_timing.sv
logic/cell_locator.sv
logic/pixel_shader.sv
logic/vga_board_display.sv
testbench/tb_vga_board_display.sv

/* Makefile */
# Verilator build for the VGA board display

VERILATOR   ?= verilator
TOP         ?= tb_vga_board_display
FILELIST    ?= compile.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --assert -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_TEXT   ?= Simulation PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
